// ==== vlog.f ====
rtl/rv32i_types.sv
rtl/pipe_ctrl.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/exec_stage.sv
rtl/writeback_stage.sv
rtl/rv_core_pipe.sv
tests/rv_core_pipe_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/100ps -f vlog.f \
    --top-module rv_core_pipe_tb -Mdir "$OBJ" -o rv_core_pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/rv_core_pipe_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
    exit 0
fi
exit 1

// ==== tests/rv_core_pipe_tb.sv ====
module rv_core_pipe_tb
import rv32i_types::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          PROG_LEN        = 64;   // matches the depth of prog below
    localparam int          MAX_LAT         = 5;
    localparam int          DRAIN_CYCLES    = 40;
    localparam int          WATCHDOG_CYCLES = PROG_LEN * 3 * (MAX_LAT + 1) + 200;
    localparam pc_t         PROG_END        = pc_t'(PROG_LEN * 4);
    localparam logic [31:0] SEED            = 32'h2b07a4b5;

    logic     clk;
    logic     rst;
    logic     imem_resp  = 1'b0;
    word_t    imem_rdata = '0;
    logic     dmem_resp  = 1'b0;
    word_t    dmem_rdata = '0;
    logic     imem_rqst;
    pc_t      imem_addr;
    logic     dmem_rqst;
    logic     dmem_we;
    pc_t      dmem_addr;
    word_t    dmem_wdata;
    logic     retire_valid;
    pc_t      retire_pc;
    reg_idx_t retire_rd;
    word_t    retire_data;

    word_t    prog [64];
    word_t    dmem [256];
    pc_t      exp_pc [$];
    reg_idx_t exp_rd [$];
    word_t    exp_val [$];
    bit       exp_chk [$];
    pc_t      st_addr [$];
    word_t    st_data [$];
    int       imem_wait    = 0;
    int       dmem_wait    = 0;
    logic     imem_busy    = 1'b0;
    logic     dmem_busy    = 1'b0;
    word_t    imem_word;
    word_t    dmem_word;
    int       mismatches   = 0;
    int       other_errors = 0;
    int       retired      = 0;
    logic     first_cycle  = 1'b1;

    rv_core_pipe u_dut (.*);

    //////////////////////////////////////////////////
    // instruction encoders, field order from the ISA manual
    //////////////////////////////////////////////////

    function automatic word_t add_instr(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        return {7'd0, rs2, rs1, F3_ADD, rd, OP_OP};
    endfunction

    function automatic word_t addi_instr(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, F3_ADD, rd, OP_IMM};
    endfunction

    function automatic word_t lw_instr(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, F3_LW, rd, OP_LOAD};
    endfunction

    function automatic word_t sw_instr(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t branch_instr(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                           logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t jal_instr(reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic reg_idx_t pick_reg(int lo, int hi);
        return reg_idx_t'($urandom_range(hi, lo));
    endfunction

    function automatic word_t fill_word(pc_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a3c_0f0f;
    endfunction

    function automatic word_t instr_at(pc_t addr);
        if (addr < PROG_END) begin
            return prog[addr[7:2]];
        end
        return word_t'(NOP_INSTR);   // past the program the core only fetches bubbles
    endfunction

    //////////////////////////////////////////////////
    // program: directed head, random forward-only tail
    //////////////////////////////////////////////////

    task automatic build_program();
        int sel;
        int k;
        prog[0]  = addi_instr(5'd8, 5'd0, 12'h100);   // x8 is the data base and is never rewritten
        prog[1]  = addi_instr(5'd1, 5'd0, 12'd5);
        prog[2]  = add_instr(5'd2, 5'd1, 5'd1);
        prog[3]  = add_instr(5'd3, 5'd2, 5'd1);
        prog[4]  = addi_instr(5'd3, 5'd3, 12'hff9);
        prog[5]  = sw_instr(5'd3, 5'd8, 12'd0);
        prog[6]  = lw_instr(5'd4, 5'd8, 12'd0);
        prog[7]  = add_instr(5'd5, 5'd4, 5'd4);       // uses the load right away
        prog[8]  = branch_instr(F3_BEQ, 5'd5, 5'd5, 13'd8);
        prog[9]  = addi_instr(5'd6, 5'd0, 12'd1);     // wrong path
        prog[10] = branch_instr(F3_BNE, 5'd1, 5'd1, 13'd8);
        prog[11] = jal_instr(5'd7, 21'd8);
        prog[12] = addi_instr(5'd6, 5'd0, 12'd2);     // wrong path
        prog[13] = sw_instr(5'd7, 5'd8, 12'd4);
        for (int i = 14; i < PROG_LEN; i++) begin
            sel = $urandom_range(9, 0);
            k   = $urandom_range(3, 1);
            if (i + k > PROG_LEN) begin
                k = PROG_LEN - i;
            end
            case (sel)
                0, 1, 2: prog[i] = add_instr(pick_reg(1, 7), pick_reg(0, 7), pick_reg(0, 7));
                3, 4:    prog[i] = addi_instr(pick_reg(1, 7), pick_reg(0, 7), 12'($urandom));
                5:       prog[i] = lw_instr(pick_reg(1, 7), 5'd8, 12'(4 * $urandom_range(15, 0)));
                6:       prog[i] = sw_instr(pick_reg(0, 7), 5'd8, 12'(4 * $urandom_range(15, 0)));
                7:       prog[i] = branch_instr(F3_BEQ, pick_reg(0, 3), pick_reg(0, 3), 13'(4 * k));
                8:       prog[i] = branch_instr(F3_BNE, pick_reg(0, 3), pick_reg(0, 3), 13'(4 * k));
                default: prog[i] = jal_instr(pick_reg(1, 7), 21'(4 * k));
            endcase
        end
    endtask

    //////////////////////////////////////////////////
    // reference ISS, fills the expected retire trace and store list
    //////////////////////////////////////////////////

    function automatic void simulate_program();
        word_t    regs [32];
        word_t    mem [256];
        pc_t      pc;
        pc_t      next_pc;
        pc_t      addr;
        word_t    w;
        word_t    a;
        word_t    b;
        word_t    imm_i;
        word_t    value;
        logic     writes;
        reg_idx_t rd;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(pc_t'(i * 4));
        end
        pc = RESET_PC;
        while (pc < PROG_END) begin
            w       = prog[pc[7:2]];
            rd      = w[11:7];
            a       = regs[w[19:15]];
            b       = regs[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            writes  = 1'b0;
            value   = '0;
            next_pc = pc + 32'd4;
            case (w[6:0])
                OP_OP: begin
                    writes = 1'b1;
                    value  = a + b;
                end
                OP_IMM: begin
                    writes = 1'b1;
                    value  = a + imm_i;
                end
                OP_LOAD: begin
                    addr   = a + imm_i;
                    writes = 1'b1;
                    value  = mem[addr[9:2]];
                end
                OP_STORE: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    mem[addr[9:2]] = b;
                    st_addr.push_back(addr);
                    st_data.push_back(b);
                end
                OP_BRANCH: begin
                    if ((w[14:12] == F3_BEQ) ? (a == b) : (a != b)) begin
                        next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                OP_JAL: begin
                    writes  = 1'b1;
                    value   = pc + 32'd4;
                    next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                default: begin
                end
            endcase
            if (writes && (rd != 5'd0)) begin
                regs[rd] = value;
            end
            exp_pc.push_back(pc);
            exp_rd.push_back(writes ? rd : 5'd0);
            exp_val.push_back(value);
            exp_chk.push_back(writes && (rd != 5'd0));
            pc = next_pc;
        end
    endfunction

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic compare_pc(string name, pc_t expected, pc_t actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic compare_word(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic compare_reg(string name, reg_idx_t expected, reg_idx_t actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected x%0d, actual x%0d", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic note_failure(string msg);
        $display("error: %s", msg);
        other_errors++;
    endtask

    // outputs are sampled at the rising edge, they settled after the falling edge
    always @(posedge clk) begin
        bit    chk;
        word_t val;
        if (!rst) begin
            if (first_cycle) begin
                first_cycle = 1'b0;
                if (imem_rqst !== 1'b1) begin
                    note_failure("no instruction request in the first cycle after reset");
                end
                compare_pc("reset fetch address", RESET_PC, imem_addr);
                if (retire_valid !== 1'b0 || dmem_rqst !== 1'b0) begin
                    note_failure("retire or data request active right after reset");
                end
            end
            if (imem_rqst && imem_busy) begin
                note_failure("instruction request issued while one is outstanding");
            end
            if (dmem_rqst && dmem_busy) begin
                note_failure("data request issued while one is outstanding");
            end
            if (retire_valid) begin
                if (exp_pc.size() == 0) begin
                    note_failure("an instruction retired beyond the end of the program");
                end else begin
                    chk = exp_chk.pop_front();
                    val = exp_val.pop_front();
                    compare_pc($sformatf("retire %0d pc", retired), exp_pc.pop_front(), retire_pc);
                    compare_reg($sformatf("retire %0d rd", retired), exp_rd.pop_front(), retire_rd);
                    if (chk) begin
                        compare_word($sformatf("retire %0d data", retired), val, retire_data);
                    end
                    retired++;
                end
            end
            if (dmem_rqst && dmem_we) begin
                if (st_addr.size() == 0) begin
                    note_failure("the core issued a store the program does not contain");
                end else begin
                    compare_pc("store address", st_addr.pop_front(), dmem_addr);
                    compare_word("store data", st_data.pop_front(), dmem_wdata);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // memory models with random latency
    //////////////////////////////////////////////////

    initial begin
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(pc_t'(i * 4));
        end
        forever begin
            @(posedge clk);
            if (!rst && imem_rqst) begin
                imem_word = instr_at(imem_addr);
                imem_wait = $urandom_range(MAX_LAT, 1);
            end
            if (!rst && dmem_rqst) begin
                if (dmem_we) begin
                    dmem[dmem_addr[9:2]] = dmem_wdata;
                end
                dmem_word = dmem[dmem_addr[9:2]];
                dmem_wait = $urandom_range(MAX_LAT, 1);
            end
            @(negedge clk);
            imem_resp  = 1'b0;
            imem_rdata = $urandom;   // junk between responses
            dmem_resp  = 1'b0;
            dmem_rdata = $urandom;
            if (imem_wait > 0) begin
                imem_wait = imem_wait - 1;
                if (imem_wait == 0) begin
                    imem_resp  = 1'b1;
                    imem_rdata = imem_word;
                end
            end
            if (dmem_wait > 0) begin
                dmem_wait = dmem_wait - 1;
                if (dmem_wait == 0) begin
                    dmem_resp  = 1'b1;
                    dmem_rdata = dmem_word;
                end
            end
            imem_busy = (imem_wait > 0);
            dmem_busy = (dmem_wait > 0);
        end
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the core hung with %0d instructions still to retire", exp_pc.size());
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int missing;
        missing = 0;
        void'($urandom(SEED));
        rst = 1'b1;
        build_program();
        simulate_program();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (exp_pc.size() != 0) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);   // any late retire or store still gets seen
        if (st_addr.size() != 0) begin
            $display("error: %0d expected stores were never issued", st_addr.size());
            missing = 1;
        end
        $display("errors: %0d mismatches, %0d other failures, %0d instructions retired",
                 mismatches, other_errors + missing, retired);
        if (mismatches == 0 && other_errors + missing == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/rv_core_pipe.sv ====
module rv_core_pipe
import rv32i_types::*;
(
    input  logic     clk,
    input  logic     rst,
    output logic     imem_rqst,
    output pc_t      imem_addr,
    input  logic     imem_resp,
    input  word_t    imem_rdata,
    output logic     dmem_rqst,
    output logic     dmem_we,
    output pc_t      dmem_addr,
    output word_t    dmem_wdata,
    input  logic     dmem_resp,
    input  word_t    dmem_rdata,
    output logic     retire_valid,
    output pc_t      retire_pc,
    output reg_idx_t retire_rd,
    output word_t    retire_data
);

    logic     move_pipeline;
    logic     flush_delay;
    logic     branch_flush;
    pc_t      redirect_pc;
    instr_u   f_instr;
    pc_t      f_pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rdata1;
    word_t    rdata2;
    instr_u   x_instr;
    pc_t      x_pc;
    word_t    x_result;
    logic     wb_we;
    reg_idx_t wb_rd;
    word_t    wb_data;

    pipe_ctrl u_ctrl (
        .clk, .rst, .imem_rqst, .dmem_rqst, .imem_resp, .dmem_resp,
        .branch_flush, .move_pipeline, .flush_delay
    );

    fetch_stage u_fetch (
        .clk, .rst, .move_pipeline, .branch_flush, .flush_delay, .redirect_pc,
        .imem_resp, .imem_rdata, .imem_rqst, .imem_addr, .f_instr, .f_pc
    );

    reg_file u_regs (
        .clk, .rst, .rs1, .rs2, .we(wb_we), .rd(wb_rd), .wdata(wb_data),
        .rdata1, .rdata2
    );

    exec_stage u_exec (
        .clk, .rst, .move_pipeline, .f_instr, .f_pc, .rdata1, .rdata2,
        .wb_we, .wb_rd, .wb_data, .rs1, .rs2, .branch_flush, .redirect_pc,
        .dmem_rqst, .dmem_we, .dmem_addr, .dmem_wdata, .x_instr, .x_pc, .x_result
    );

    writeback_stage u_wb (
        .clk, .rst, .move_pipeline, .x_instr, .x_pc, .x_result, .dmem_resp,
        .dmem_rdata, .wb_we, .wb_rd, .wb_data, .retire_valid, .retire_pc, .retire_rd
    );

    assign retire_data = wb_data;

endmodule

// ==== rtl/writeback_stage.sv ====
module writeback_stage
import rv32i_types::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     move_pipeline,
    input  instr_u   x_instr,
    input  pc_t      x_pc,
    input  word_t    x_result,
    input  logic     dmem_resp,
    input  word_t    dmem_rdata,
    output logic     wb_we,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     retire_valid,
    output pc_t      retire_pc,
    output reg_idx_t retire_rd
);

    instr_u     w_instr;
    pc_t        w_pc;
    word_t      w_result;
    word_t      load_q;
    logic [6:0] opcode;
    logic       is_load;
    logic       writes_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            w_instr <= NOP_INSTR;
        end else if (move_pipeline) begin
            w_instr <= x_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (move_pipeline) begin
            w_pc     <= x_pc;
            w_result <= x_result;
        end
        if (dmem_resp) begin
            load_q <= dmem_rdata;   // may arrive several cycles before the next move
        end
    end

    assign opcode    = w_instr.i.opcode;
    assign is_load   = (opcode == OP_LOAD);
    assign writes_rd = (opcode == OP_OP) || (opcode == OP_IMM) || is_load || (opcode == OP_JAL);

    assign wb_rd   = writes_rd ? w_instr.i.rd : '0;
    assign wb_data = !is_load ? w_result : (dmem_resp ? dmem_rdata : load_q);

    // bubbles are the canonical NOP and never retire
    assign retire_valid = move_pipeline && (w_instr != NOP_INSTR);
    assign wb_we        = retire_valid && writes_rd;
    assign retire_pc    = w_pc;
    assign retire_rd    = wb_rd;

endmodule

// ==== rtl/exec_stage.sv ====
module exec_stage
import rv32i_types::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     move_pipeline,
    input  instr_u   f_instr,
    input  pc_t      f_pc,
    input  word_t    rdata1,
    input  word_t    rdata2,
    input  logic     wb_we,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output logic     branch_flush,
    output pc_t      redirect_pc,
    output logic     dmem_rqst,
    output logic     dmem_we,
    output pc_t      dmem_addr,
    output word_t    dmem_wdata,
    output instr_u   x_instr,
    output pc_t      x_pc,
    output word_t    x_result
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_add;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_jal;
    logic       taken;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      src1;
    word_t      src2;
    word_t      operand_b;
    word_t      sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            x_instr <= NOP_INSTR;
        end else if (move_pipeline) begin
            x_instr <= f_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (move_pipeline) begin
            x_pc <= f_pc;
        end
    end

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    assign opcode = x_instr.r.opcode;
    assign funct3 = x_instr.r.funct3;
    assign rs1    = x_instr.r.rs1;     // register fields sit at the same bits in every format
    assign rs2    = x_instr.r.rs2;

    assign is_add    = (opcode == OP_OP) && (funct3 == F3_ADD) && (x_instr.r.funct7 == '0);
    assign is_load   = (opcode == OP_LOAD) && (funct3 == F3_LW);
    assign is_store  = (opcode == OP_STORE) && (funct3 == F3_SW);
    assign is_branch = (opcode == OP_BRANCH);
    assign is_jal    = (opcode == OP_JAL);

    assign imm_i = {{20{x_instr.i.imm[11]}}, x_instr.i.imm};
    assign imm_s = {{20{x_instr.sb.imm_hi[6]}}, x_instr.sb.imm_hi, x_instr.sb.imm_lo};
    assign imm_b = {{19{x_instr.sb.imm_hi[6]}}, x_instr.sb.imm_hi[6], x_instr.sb.imm_lo[0],
                    x_instr.sb.imm_hi[5:0], x_instr.sb.imm_lo[4:1], 1'b0};
    assign imm_j = {{11{x_instr.j.imm[19]}}, x_instr.j.imm[19], x_instr.j.imm[7:0],
                    x_instr.j.imm[8], x_instr.j.imm[18:9], 1'b0};

    //////////////////////////////////////////////////
    // operands, ALU and branch resolution
    //////////////////////////////////////////////////

    // W retires in the same move, so its result overrides the file
    assign src1 = (wb_we && (wb_rd != '0) && (wb_rd == rs1)) ? wb_data : rdata1;
    assign src2 = (wb_we && (wb_rd != '0) && (wb_rd == rs2)) ? wb_data : rdata2;

    always_comb begin
        if (is_add) begin
            operand_b = src2;
        end else if (is_store) begin
            operand_b = imm_s;
        end else begin
            operand_b = imm_i;
        end
    end

    assign sum = src1 + operand_b;

    always_comb begin
        taken = 1'b0;
        if (is_branch) begin
            case (funct3)
                F3_BEQ:  taken = (src1 == src2);
                F3_BNE:  taken = (src1 != src2);
                default: taken = 1'b0;
            endcase
        end
    end

    assign branch_flush = taken || is_jal;
    assign redirect_pc  = x_pc + (is_jal ? imm_j : imm_b);

    // JAL writes its link; loads carry the address and W swaps in the data
    assign x_result = is_jal ? x_pc + INSTR_BYTES : sum;

    assign dmem_rqst  = move_pipeline && (is_load || is_store);
    assign dmem_we    = is_store;
    assign dmem_addr  = sum;
    assign dmem_wdata = src2;

endmodule

// ==== rtl/reg_file.sv ====
module reg_file
import rv32i_types::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     we,
    input  reg_idx_t rd,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero, and a write in the same cycle is visible at once
    assign rdata1 = (rs1 == '0) ? '0 :
                    (we && (rd == rs1)) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 :
                    (we && (rd == rs2)) ? wdata : regs[rs2];

endmodule

// ==== rtl/fetch_stage.sv ====
module fetch_stage
import rv32i_types::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   move_pipeline,
    input  logic   branch_flush,
    input  logic   flush_delay,
    input  pc_t    redirect_pc,
    input  logic   imem_resp,
    input  word_t  imem_rdata,
    output logic   imem_rqst,
    output pc_t    imem_addr,
    output instr_u f_instr,
    output pc_t    f_pc
);

    pc_t    pc_q;
    pc_t    req_pc_q;
    instr_u instr_q;
    instr_u fetched;

    assign imem_rqst = move_pipeline;   // one fetch per move
    assign imem_addr = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (move_pipeline) begin
            pc_q <= branch_flush ? redirect_pc : pc_q + INSTR_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (move_pipeline) begin
            req_pc_q <= pc_q;   // pc of the request now in flight
        end
    end

    // reset value feeds a bubble into X on the very first move
    always_ff @(posedge clk) begin
        if (rst) begin
            instr_q <= NOP_INSTR;
        end else if (imem_resp) begin
            instr_q <= imem_rdata;
        end
    end

    // the move usually lands in the same cycle as the response
    assign fetched = imem_resp ? instr_u'(imem_rdata) : instr_q;

    // the word behind a redirecting branch and the one still in flight are both wrong path
    assign f_instr = (branch_flush || flush_delay) ? NOP_INSTR : fetched;
    assign f_pc    = req_pc_q;

endmodule

// ==== rtl/pipe_ctrl.sv ====
module pipe_ctrl
import rv32i_types::*;
(
    input  logic clk,
    input  logic rst,
    input  logic imem_rqst,
    input  logic dmem_rqst,
    input  logic imem_resp,
    input  logic dmem_resp,
    input  logic branch_flush,
    output logic move_pipeline,
    output logic flush_delay
);

    logic [1:0] stall_q;
    logic [1:0] stall_d;
    logic [1:0] issue_state;
    logic       flush_q;
    logic       flush_d;

    //////////////////////////////////////////////////
    // stall machine
    //////////////////////////////////////////////////

    // wait state implied by the requests leaving on this move
    always_comb begin
        if (imem_rqst && dmem_rqst) begin
            issue_state = ST_BOTH_WAIT;
        end else if (imem_rqst) begin
            issue_state = ST_IMEM_WAIT;
        end else if (dmem_rqst) begin
            issue_state = ST_DMEM_WAIT;
        end else begin
            issue_state = ST_IDLE;
        end
    end

    always_comb begin
        move_pipeline = 1'b0;
        stall_d       = stall_q;

        case (stall_q)
            ST_IDLE: begin
                move_pipeline = 1'b1;
            end
            ST_IMEM_WAIT: begin
                move_pipeline = imem_resp;
            end
            ST_DMEM_WAIT: begin
                move_pipeline = dmem_resp;
            end
            ST_BOTH_WAIT: begin
                move_pipeline = imem_resp && dmem_resp;
                if (imem_resp && !dmem_resp) begin
                    stall_d = ST_DMEM_WAIT;   // data still owed
                end else if (dmem_resp && !imem_resp) begin
                    stall_d = ST_IMEM_WAIT;
                end
            end
            default: begin
                stall_d = ST_IDLE;
            end
        endcase

        if (move_pipeline) begin
            stall_d = issue_state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_q <= ST_IDLE;
        end else begin
            stall_q <= stall_d;
        end
    end

    //////////////////////////////////////////////////
    // flush-delay machine
    //////////////////////////////////////////////////

    // stays in the delay state until a move that carries no redirect
    always_comb begin
        flush_d = flush_q;
        case (flush_q)
            FL_IDLE: begin
                if (move_pipeline && branch_flush) begin
                    flush_d = FL_DELAY;
                end
            end
            FL_DELAY: begin
                if (move_pipeline && !branch_flush) begin
                    flush_d = FL_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flush_q <= FL_IDLE;
        end else begin
            flush_q <= flush_d;
        end
    end

    assign flush_delay = (flush_q == FL_DELAY);

endmodule

// ==== rtl/rv32i_types.sv ====
package rv32i_types;

    //////////////////////////////////////////////////
    // widths and basic types
    //////////////////////////////////////////////////

    localparam int xlen_w = 32;

    typedef logic [xlen_w-1:0] word_t;
    typedef logic [xlen_w-1:0] pc_t;
    typedef logic [4:0]        reg_idx_t;

    localparam pc_t RESET_PC    = 32'h0000_0000;
    localparam pc_t INSTR_BYTES = 32'd4;           // fixed 32-bit encodings, no compressed set

    //////////////////////////////////////////////////
    // opcodes and funct3 codes of the supported subset
    //////////////////////////////////////////////////

    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;

    // state encodings of the control block
    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_IMEM_WAIT = 2'd1;
    localparam logic [1:0] ST_DMEM_WAIT = 2'd2;
    localparam logic [1:0] ST_BOTH_WAIT = 2'd3;
    localparam logic       FL_IDLE      = 1'b0;
    localparam logic       FL_DELAY     = 1'b1;

    //////////////////////////////////////////////////
    // instruction formats
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]  imm_hi;    // B format scrambles these bits differently than S
        reg_idx_t    rs2;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } sb_fmt_t;

    typedef struct packed {
        logic [6:0]  funct7;
        reg_idx_t    rs2;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } j_fmt_t;

    typedef union packed {
        i_fmt_t  i;
        sb_fmt_t sb;
        r_fmt_t  r;
        j_fmt_t  j;
    } instr_u;

    localparam instr_u NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

endpackage
